/* design/ntm_inv_consts.svh */
// Width and depth constants of the modular inversion unit
`ifndef NTM_INV_CONSTS_SVH
`define NTM_INV_CONSTS_SVH

////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////

// Operand, modulus and result word
`define NTM_INV_DATA_SIZE 32
// Sequence tag, wraps around
`define NTM_INV_TAG_SIZE 4

// Request FIFO entries
`define NTM_INV_FIFO_DEPTH 4

`endif

/* design/ntm_inv_pkg.sv */
// Package with the sequence tag type and the request struct
`default_nettype none

package ntm_inv_pkg;

  `include "ntm_inv_consts.svh"

  ////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////

  // Sequence tag of an accepted request
  typedef logic [`NTM_INV_TAG_SIZE-1:0] inv_tag_t;

  // One queued request, tag on top
  typedef struct packed {
    inv_tag_t                       tag;
    logic [`NTM_INV_DATA_SIZE-1:0] operand;
    logic [`NTM_INV_DATA_SIZE-1:0] modulus;
  } inv_req_t;

endpackage

`default_nettype wire

/* design/ntm_inv_req_if.sv */
// Request interface between screen, FIFO and inverter, with its modports
`timescale 1ns/1ps
`default_nettype none

interface ntm_inv_req_if;

  import ntm_inv_pkg::*;

  // Write side, screen into FIFO
  logic     push;
  logic     full;
  inv_req_t wr_item;

  // Read side, FIFO head into inverter
  logic     pop;
  logic     empty;
  inv_req_t rd_item;

  // Producer
  modport writer (output push, output wr_item, input full);

  // Storage
  modport buffer (input push, input wr_item, input pop,
                  output full, output empty, output rd_item);

  // Consumer
  modport reader (output pop, input empty, input rd_item);

endinterface

`default_nettype wire

/* design/ntm_request_screen.sv */
// Request screen: operand check, tag assignment, FIFO push and reject pulse
`timescale 1ns/1ps
`default_nettype none

`include "ntm_inv_consts.svh"

module ntm_request_screen (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          REQ_STROBE,
  input  logic [`NTM_INV_DATA_SIZE-1:0] REQ_DATA,
  input  logic [`NTM_INV_DATA_SIZE-1:0] REQ_MODULO,
  output logic                          REJECT,
  ntm_inv_req_if.writer                 wr
);

  import ntm_inv_pkg::*;

  ////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////

  // Next tag to hand out
  inv_tag_t tag_q;

  // Operand and modulus checks
  logic mod_odd;
  logic mod_big;
  logic data_nonzero;
  logic req_valid;

  // Strobe outcome
  logic accept;

  ////////////////////////////////////////////////////
  // Screening
  ////////////////////////////////////////////////////

  // Odd modulus
  assign mod_odd = REQ_MODULO[0];

  // Any upper bit set, so an odd modulus is 3 or more
  assign mod_big = |REQ_MODULO[`NTM_INV_DATA_SIZE-1:1];

  // Zero has no inverse
  assign data_nonzero = |REQ_DATA;

  assign req_valid = mod_odd && mod_big && data_nonzero;

  // Room in the FIFO is part of the rule
  assign accept = REQ_STROBE && req_valid && !wr.full;

  ////////////////////////////////////////////////////
  // FIFO push
  ////////////////////////////////////////////////////

  // Same cycle as the strobe
  assign wr.push = accept;

  assign wr.wr_item = '{tag: tag_q, operand: REQ_DATA, modulus: REQ_MODULO};

  ////////////////////////////////////////////////////
  // Tag counter and reject pulse
  ////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      tag_q  <= '0;
      REJECT <= 1'b0;
    end else begin
      // Tag advances only on accepted requests
      if (accept) begin
        tag_q <= tag_q + 1'b1;
      end
      // One cycle after a strobe that was not taken
      REJECT <= REQ_STROBE && !accept;
    end
  end

endmodule

`default_nettype wire

/* design/ntm_request_fifo.sv */
// Circular request FIFO with full and empty levels
`timescale 1ns/1ps
`default_nettype none

`include "ntm_inv_consts.svh"

module ntm_request_fifo (
  input  logic          CLK,
  input  logic          RST,
  ntm_inv_req_if.buffer buf_side
);

  import ntm_inv_pkg::*;

  ////////////////////////////////////////////////////
  // Parameters
  ////////////////////////////////////////////////////

  localparam int DEPTH = `NTM_INV_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  ////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////

  // Request storage
  inv_req_t mem [DEPTH];

  // Pointers and occupancy
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Qualified transfers
  logic do_push;
  logic do_pop;

  ////////////////////////////////////////////////////
  // Levels and head
  ////////////////////////////////////////////////////

  assign buf_side.full  = (count == CNT_W'(DEPTH));
  assign buf_side.empty = (count == '0);

  // Head entry, valid while not empty
  assign buf_side.rd_item = mem[rd_ptr];

  assign do_push = buf_side.push && !buf_side.full;
  assign do_pop  = buf_side.pop && !buf_side.empty;

  ////////////////////////////////////////////////////
  // Storage write
  ////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= buf_side.wr_item;
    end
  end

  ////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at the last entry
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/ntm_scalar_inverter.sv */
// Scalar modular inverter FSM, binary extended Euclid over popped requests
`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_inverter #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 CLK,
  input  logic                 RST,
  ntm_inv_req_if.reader        rd,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  output ntm_inv_pkg::inv_tag_t TAG_OUT,
  output logic                 NO_INVERSE
);

  import ntm_inv_pkg::*;

  ////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    STARTER,
    ENDER,
    CHECK_U,
    CHECK_V,
    CHECK_D
  } inv_state_t;

  ////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////

  inv_state_t state;

  // Working values, one spare bit for the modulus additions
  logic [DATA_SIZE:0] u_q;
  logic [DATA_SIZE:0] v_q;
  logic [DATA_SIZE:0] x_q;
  logic [DATA_SIZE:0] y_q;

  // Latched request fields
  logic [DATA_SIZE-1:0] mod_q;
  inv_tag_t             tag_q;
  logic [DATA_SIZE:0]   mod_ext;

  // ENDER decisions
  logic u_one;
  logic v_one;
  logic no_inv;
  logic x_lt;
  logic y_lt;
  logic finish;

  ////////////////////////////////////////////////////
  // Decisions
  ////////////////////////////////////////////////////

  assign mod_ext = {1'b0, mod_q};

  assign u_one  = (u_q == (DATA_SIZE+1)'(1));
  assign v_one  = (v_q == (DATA_SIZE+1)'(1));
  // A zero means u and v met at a gcd above 1
  assign no_inv = (u_q == '0) || (v_q == '0);
  assign x_lt   = (x_q < mod_ext);
  assign y_lt   = (y_q < mod_ext);

  // Result ready once the matching coefficient is reduced
  assign finish = (state == ENDER) &&
                  (no_inv || (u_one && x_lt) || (!u_one && v_one && y_lt));

  // Pop at the first idle edge with data
  assign rd.pop = (state == STARTER) && !rd.empty;

  ////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= STARTER;
      READY      <= 1'b0;
      NO_INVERSE <= 1'b0;
    end else begin
      // One-cycle result strobe
      READY      <= finish;
      NO_INVERSE <= finish && no_inv;
      case (state)
        STARTER: begin
          if (!rd.empty) begin
            state <= ENDER;
          end
        end
        ENDER: begin
          if (finish) begin
            state <= STARTER;
          end else if (u_one || v_one) begin
            // Stay while the coefficient is reduced
            state <= ENDER;
          end else if (!u_q[0]) begin
            state <= CHECK_U;
          end else if (!v_q[0]) begin
            state <= CHECK_V;
          end else begin
            state <= CHECK_D;
          end
        end
        // Every step goes back through the end test
        CHECK_U: state <= ENDER;
        CHECK_V: state <= ENDER;
        CHECK_D: state <= ENDER;
        default: state <= STARTER;
      endcase
    end
  end

  ////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////

  // Invariants x*a = u and y*a = v, both mod m
  always_ff @(posedge CLK) begin
    case (state)
      STARTER: begin
        if (!rd.empty) begin
          u_q   <= {1'b0, DATA_SIZE'(rd.rd_item.operand)};
          v_q   <= {1'b0, DATA_SIZE'(rd.rd_item.modulus)};
          x_q   <= (DATA_SIZE+1)'(1);
          y_q   <= '0;
          mod_q <= DATA_SIZE'(rd.rd_item.modulus);
          tag_q <= rd.rd_item.tag;
        end
      end
      ENDER: begin
        if (finish) begin
          TAG_OUT <= tag_q;
          if (no_inv) begin
            DATA_OUT <= '0;
          end else if (u_one) begin
            DATA_OUT <= x_q[DATA_SIZE-1:0];
          end else begin
            DATA_OUT <= y_q[DATA_SIZE-1:0];
          end
        end else if (u_one) begin
          // Repeated subtraction below the modulus
          x_q <= x_q - mod_ext;
        end else if (v_one) begin
          y_q <= y_q - mod_ext;
        end
      end
      CHECK_U: begin
        // Halve u and x, odd x made even with the odd modulus
        u_q <= u_q >> 1;
        x_q <= x_q[0] ? ((x_q + mod_ext) >> 1) : (x_q >> 1);
      end
      CHECK_V: begin
        v_q <= v_q >> 1;
        y_q <= y_q[0] ? ((y_q + mod_ext) >> 1) : (y_q >> 1);
      end
      CHECK_D: begin
        // Larger minus smaller, coefficients kept below m
        if (u_q < v_q) begin
          v_q <= v_q - u_q;
          y_q <= (y_q >= x_q) ? (y_q - x_q) : (y_q + mod_ext - x_q);
        end else begin
          u_q <= u_q - v_q;
          x_q <= (x_q >= y_q) ? (x_q - y_q) : (x_q + mod_ext - y_q);
        end
      end
      default: begin
        u_q <= u_q;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/ntm_inverse_unit.sv */
// Top level of the modular inversion unit: screen, request FIFO and inverter
`timescale 1ns/1ps
`default_nettype none

`include "ntm_inv_consts.svh"

module ntm_inverse_unit (
  input  logic                          CLK,
  input  logic                          RST,
  // Request side
  input  logic                          REQ_STROBE,
  input  logic [`NTM_INV_DATA_SIZE-1:0] REQ_DATA,
  input  logic [`NTM_INV_DATA_SIZE-1:0] REQ_MODULO,
  output logic                          REQ_FULL,
  output logic                          REJECT,
  // Result side, no back-pressure
  output logic                          RES_READY,
  output logic [`NTM_INV_DATA_SIZE-1:0] RES_DATA,
  output logic [`NTM_INV_TAG_SIZE-1:0]  RES_TAG,
  output logic                          RES_NO_INVERSE
);

  ////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////

  ntm_inv_req_if req_if ();

  // Full level straight out for the requester
  assign REQ_FULL = req_if.full;

  // Producer
  ntm_request_screen u_screen (
    .CLK        (CLK),
    .RST        (RST),
    .REQ_STROBE (REQ_STROBE),
    .REQ_DATA   (REQ_DATA),
    .REQ_MODULO (REQ_MODULO),
    .REJECT     (REJECT),
    .wr         (req_if.writer)
  );

  // Buffer
  ntm_request_fifo u_fifo (
    .CLK      (CLK),
    .RST      (RST),
    .buf_side (req_if.buffer)
  );

  ////////////////////////////////////////////////////
  // Inversion
  ////////////////////////////////////////////////////

  // Consumer, results in request order
  ntm_scalar_inverter #(
    .DATA_SIZE (`NTM_INV_DATA_SIZE)
  ) u_inverter (
    .CLK        (CLK),
    .RST        (RST),
    .rd         (req_if.reader),
    .READY      (RES_READY),
    .DATA_OUT   (RES_DATA),
    .TAG_OUT    (RES_TAG),
    .NO_INVERSE (RES_NO_INVERSE)
  );

endmodule

`default_nettype wire

/* verif/ntm_inverse_unit_tb.sv */
// Testbench for the modular inversion unit with random requests, Euclid model, scoreboard and checks
`timescale 1ns/1ps
`default_nettype none

`include "ntm_inv_consts.svh"

module ntm_inverse_unit_tb;

  localparam int DW = `NTM_INV_DATA_SIZE;
  localparam int TW = `NTM_INV_TAG_SIZE;
  localparam int TIMEOUT_CYCLES = 4000;

  ////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////

  logic          CLK;
  logic          RST;
  logic          REQ_STROBE;
  logic [DW-1:0] REQ_DATA;
  logic [DW-1:0] REQ_MODULO;
  logic          REQ_FULL;
  logic          REJECT;
  logic          RES_READY;
  logic [DW-1:0] RES_DATA;
  logic [TW-1:0] RES_TAG;
  logic          RES_NO_INVERSE;

  // Scoreboard with one entry per accepted request
  logic [DW-1:0] exp_data_q[$];
  logic [TW-1:0] exp_tag_q[$];
  logic          exp_noinv_q[$];

  // Model and monitor state
  integer        seed;
  string         test_name;
  logic [TW-1:0] model_tag;
  logic          rej_pending;
  logic          full_seen;
  int            strobe_count;
  int            full_strobe_count;
  int            reject_count;
  int            result_count;

  ntm_inverse_unit u_dut (
    .CLK            (CLK),
    .RST            (RST),
    .REQ_STROBE     (REQ_STROBE),
    .REQ_DATA       (REQ_DATA),
    .REQ_MODULO     (REQ_MODULO),
    .REQ_FULL       (REQ_FULL),
    .REJECT         (REJECT),
    .RES_READY      (RES_READY),
    .RES_DATA       (RES_DATA),
    .RES_TAG        (RES_TAG),
    .RES_NO_INVERSE (RES_NO_INVERSE)
  );

  // 4 ns clock
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////

  function automatic longint unsigned model_gcd(input longint unsigned a,
                                                input longint unsigned b);
    longint unsigned t;
    while (b != 0) begin
      t = a % b;
      a = b;
      b = t;
    end
    return a;
  endfunction

  // Ordinary extended Euclid with the coefficient of a brought into [0, m)
  function automatic longint unsigned model_inverse(input longint a, input longint m);
    longint r0;
    longint r1;
    longint s0;
    longint s1;
    longint q;
    longint t;
    r0 = a;
    r1 = m;
    s0 = 1;
    s1 = 0;
    while (r1 != 0) begin
      q  = r0 / r1;
      t  = r0 - q * r1;
      r0 = r1;
      r1 = t;
      t  = s0 - q * s1;
      s0 = s1;
      s1 = t;
    end
    s0 = s0 % m;
    if (s0 < 0) begin
      s0 = s0 + m;
    end
    return s0;
  endfunction

  // Odd modulus of 3 or more, nonzero operand
  function automatic logic request_valid(input logic [DW-1:0] a, input logic [DW-1:0] m);
    return m[0] && (m >= 3) && (a != 0);
  endfunction

  ////////////////////////////////////////////////////
  // Checks and failure exit
  ////////////////////////////////////////////////////

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s: expected %0h actual %0h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic queue_expected(input logic [DW-1:0] a, input logic [DW-1:0] m);
    if (model_gcd(a, m) == 1) begin
      exp_data_q.push_back(DW'(model_inverse(longint'(a), longint'(m))));
      exp_noinv_q.push_back(1'b0);
    end else begin
      // No inverse when the gcd is above 1
      exp_data_q.push_back('0);
      exp_noinv_q.push_back(1'b1);
    end
    exp_tag_q.push_back(model_tag);
    model_tag = model_tag + 1'b1;
  endtask

  ////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////

  // Strobe side sampled at the edge the screen uses
  always @(posedge CLK) begin
    logic accept;
    if (!RST) begin
      // Pulse due one cycle after a refused strobe
      check_value("REJECT", rej_pending, REJECT);
      if (REJECT) begin
        reject_count++;
      end
      rej_pending = 1'b0;
      if (REQ_STROBE) begin
        strobe_count++;
        if (REQ_FULL) begin
          full_seen = 1'b1;
          full_strobe_count++;
        end
        accept      = request_valid(REQ_DATA, REQ_MODULO) && !REQ_FULL;
        rej_pending = !accept;
        if (accept) begin
          queue_expected(REQ_DATA, REQ_MODULO);
        end
      end
    end
  end

  // Results in order against the queue head
  always @(posedge CLK) begin
    if (!RST && RES_READY) begin
      if (exp_data_q.size() == 0) begin
        $display("Unexpected result with tag %0d during %s", RES_TAG, test_name);
        abort_run();
      end else begin
        check_value("RES_TAG", exp_tag_q[0], RES_TAG);
        check_value("RES_NO_INVERSE", exp_noinv_q[0], RES_NO_INVERSE);
        check_value("RES_DATA", exp_data_q[0], RES_DATA);
        void'(exp_data_q.pop_front());
        void'(exp_tag_q.pop_front());
        void'(exp_noinv_q.pop_front());
        result_count++;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////

  task automatic pick_invertible(output logic [DW-1:0] a, output logic [DW-1:0] m,
                                 input logic narrow);
    a = '0;
    m = '0;
    while (a == 0 || model_gcd(a, m) != 1) begin
      m = $random(seed);
      a = $random(seed);
      if (narrow) begin
        m = m & 32'hFF;
        a = a & 32'hFFF;
      end
      m[0] = 1'b1;
      if (m < 3) begin
        m = 3;
      end
    end
  endtask

  // Common factor of 3 or 5 in both words
  task automatic pick_shared(output logic [DW-1:0] a, output logic [DW-1:0] m);
    logic [DW-1:0] f;
    f = ($random(seed) & 1) ? 5 : 3;
    m = f * (($random(seed) & 32'h0FFF_FFFF) | 1);
    a = f * (($random(seed) & 32'h0FFF_FFFF) + 1);
  endtask

  task automatic send_request(input logic [DW-1:0] a, input logic [DW-1:0] m);
    @(posedge CLK);
    REQ_STROBE <= 1'b1;
    REQ_DATA   <= a;
    REQ_MODULO <= m;
    @(posedge CLK);
    REQ_STROBE <= 1'b0;
    @(posedge CLK);
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_data_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    if (exp_data_q.size() != 0) begin
      $display("Timeout during %s: the result never came", test_name);
      abort_run();
    end
  endtask

  task automatic wait_reject(input int target);
    int cycles;
    cycles = 0;
    while (reject_count < target && cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    if (reject_count < target) begin
      $display("Timeout during %s: the REJECT pulse never came", test_name);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////

  initial begin
    logic [DW-1:0] a;
    logic [DW-1:0] m;
    int            rej0;
    int            res0;
    int            stb0;
    int            full0;
    seed              = 15;
    model_tag         = '0;
    rej_pending       = 1'b0;
    full_seen         = 1'b0;
    strobe_count      = 0;
    full_strobe_count = 0;
    reject_count      = 0;
    result_count      = 0;
    test_name         = "reset";
    RST        <= 1'b1;
    REQ_STROBE <= 1'b0;
    REQ_DATA   <= '0;
    REQ_MODULO <= '0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);

    // Quiet outputs before any strobe
    check_value("RES_READY", 0, RES_READY);
    check_value("REJECT", 0, REJECT);
    check_value("RES_NO_INVERSE", 0, RES_NO_INVERSE);
    check_value("REQ_FULL", 0, REQ_FULL);

    // One at a time with small and full-width words
    test_name = "invertible";
    for (int i = 0; i < 20; i++) begin
      pick_invertible(a, m, i[0]);
      send_request(a, m);
      wait_drained();
    end

    test_name = "no_inverse";
    for (int i = 0; i < 8; i++) begin
      pick_shared(a, m);
      send_request(a, m);
      wait_drained();
    end

    // Even modulus, modulus 1, zero operand; then a valid one for the tag
    test_name = "screened";
    res0 = result_count;
    for (int i = 0; i < 3; i++) begin
      pick_invertible(a, m, 1'b0);
      if (i == 0) begin
        m[0] = 1'b0;
      end else if (i == 1) begin
        m = 1;
      end else begin
        a = '0;
      end
      rej0 = reject_count;
      send_request(a, m);
      wait_reject(rej0 + 1);
    end
    check_value("results after rejects", res0, result_count);
    pick_invertible(a, m, 1'b0);
    send_request(a, m);
    wait_drained();

    // Back-to-back strobes into a small FIFO
    test_name = "burst";
    rej0  = reject_count;
    res0  = result_count;
    stb0  = strobe_count;
    full0 = full_strobe_count;
    for (int i = 0; i < 12; i++) begin
      pick_invertible(a, m, 1'b0);
      @(posedge CLK);
      REQ_STROBE <= 1'b1;
      REQ_DATA   <= a;
      REQ_MODULO <= m;
    end
    @(posedge CLK);
    REQ_STROBE <= 1'b0;
    @(posedge CLK);
    @(posedge CLK);
    wait_drained();
    check_value("rejects while full", full_strobe_count - full0, reject_count - rej0);
    check_value("results", (strobe_count - stb0) - (reject_count - rej0),
                result_count - res0);
    check_value("REQ_FULL seen", 1, full_seen);

    test_name = "end";
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+design
design/ntm_inv_pkg.sv
design/ntm_inv_req_if.sv
design/ntm_request_screen.sv
design/ntm_request_fifo.sv
design/ntm_scalar_inverter.sv
design/ntm_inverse_unit.sv
verif/ntm_inverse_unit_tb.sv
